// File: files.f
verilog/fb_pkg.sv
verilog/gfx_pattern.sv
verilog/fb_bank.sv
verilog/fb_stripe.sv
verilog/fb_reader.sv
verilog/vga_timing.sv
verilog/gfx_pattern_demo.sv
tb/tb_gfx_pattern_demo.sv

// File: Makefile
TB_TOP  = tb_gfx_pattern_demo
RTL_TOP = gfx_pattern_demo

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module $(RTL_TOP)
	verilator --lint-only --timing -f files.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TB_TOP) \
		-o sim_$(TB_TOP)
	@out="$$(./obj_dir/sim_$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: tb/tb_gfx_pattern_demo.sv
`timescale 1ns/1ps

module tb_gfx_pattern_demo;
  import fb_pkg::*;

  localparam int NUM_FRAMES      = 3;
  localparam int LINE_CYCLES     = H_LINE_END + 1;
  localparam int FRAME_LINES     = V_FRAME_END + 1;
  localparam int FRAME_CYCLES    = LINE_CYCLES * FRAME_LINES;
  localparam int NUM_FIXED       = 10;
  localparam int NUM_RANDOM      = 24;
  localparam int NUM_ENTRIES     = NUM_FIXED + NUM_RANDOM;
  localparam int WATCHDOG_CYCLES = (NUM_FRAMES + 3) * FRAME_CYCLES + 2 * FB_DEPTH;

  logic                   clk;
  logic                   rst_n;
  logic [COLOR_WIDTH-1:0] vga_red;
  logic [COLOR_WIDTH-1:0] vga_grn;
  logic [COLOR_WIDTH-1:0] vga_blu;
  logic                   vga_hsync;
  logic                   vga_vsync;
  logic                   vga_error;

  // check table, one entry per (frame, x, y) position
  int          tab_frame[NUM_ENTRIES];
  int          tab_x[NUM_ENTRIES];
  int          tab_y[NUM_ENTRIES];
  pixel_t      tab_exp[NUM_ENTRIES];
  bit          tab_hit[NUM_ENTRIES];

  int          errors;
  int          table_checks;
  logic [31:0] lcg_state;
  int          cycle_cnt;
  int          last_hfall;
  int          last_vfall;
  logic        prev_hsync;
  logic        prev_vsync;

  gfx_pattern_demo UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync),
    .vga_error(vga_error)
  );

  initial begin
    clk = 1'b0;
  end

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // red is x, green is y, blue is x xor y, black outside the visible area
  function automatic pixel_t pattern_pixel(input int x, input int y);
    pixel_t p;
    p = '0;
    if (x < H_VISIBLE && y < V_VISIBLE) begin
      p.red = COLOR_WIDTH'(x);
      p.grn = COLOR_WIDTH'(y);
      p.blu = COLOR_WIDTH'(x ^ y);
    end
    return p;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
    errors++;
  endtask

  task automatic add_entry(input int idx, input int f, input int x, input int y);
    tab_frame[idx] = f;
    tab_x[idx]     = x;
    tab_y[idx]     = y;
    tab_exp[idx]   = pattern_pixel(x, y);
    tab_hit[idx]   = 1'b0;
  endtask

  task automatic build_table();
    // corners, a few blanking positions, then random ones
    add_entry(0, 0, 0, 0);
    add_entry(1, 0, 7, 0);
    add_entry(2, 0, 0, 3);
    add_entry(3, 0, 7, 3);
    add_entry(4, 1, 3, 2);
    add_entry(5, 1, 8, 1);
    add_entry(6, 1, 2, 4);
    add_entry(7, 2, 13, 6);
    add_entry(8, 2, 5, 1);
    add_entry(9, 2, 11, 5);
    for (int i = NUM_FIXED; i < NUM_ENTRIES; i++) begin
      lcg_state = lcg_next(lcg_state);
      add_entry(i, int'(lcg_state[31:24]) % NUM_FRAMES,
                int'(lcg_state[19:12]) % LINE_CYCLES,
                int'(lcg_state[9:2]) % FRAME_LINES);
    end
  endtask

  // line and frame lengths and pulse widths, measured between sync edges
  task automatic track_sync();
    if (prev_hsync === 1'b1 && vga_hsync === 1'b0) begin
      if (last_hfall >= 0 && cycle_cnt - last_hfall != LINE_CYCLES) begin
        report_mismatch("line length", LINE_CYCLES, cycle_cnt - last_hfall);
      end
      last_hfall = cycle_cnt;
    end
    if (prev_hsync === 1'b0 && vga_hsync === 1'b1 && last_hfall >= 0) begin
      if (cycle_cnt - last_hfall != H_SYNC_END - H_SYNC_START) begin
        report_mismatch("hsync width", H_SYNC_END - H_SYNC_START, cycle_cnt - last_hfall);
      end
    end
    if (prev_vsync === 1'b1 && vga_vsync === 1'b0) begin
      if (last_vfall >= 0 && cycle_cnt - last_vfall != FRAME_CYCLES) begin
        report_mismatch("frame length", FRAME_CYCLES, cycle_cnt - last_vfall);
      end
      last_vfall = cycle_cnt;
    end
    if (prev_vsync === 1'b0 && vga_vsync === 1'b1 && last_vfall >= 0) begin
      if (cycle_cnt - last_vfall != (V_SYNC_END - V_SYNC_START) * LINE_CYCLES) begin
        report_mismatch("vsync width", (V_SYNC_END - V_SYNC_START) * LINE_CYCLES,
                        cycle_cnt - last_vfall);
      end
    end
    prev_hsync = vga_hsync;
    prev_vsync = vga_vsync;
    cycle_cnt++;
  endtask

  task automatic check_position(input int frame, input int h, input int v);
    logic   exp_hsync;
    logic   exp_vsync;
    pixel_t got;
    exp_hsync = !(h >= H_SYNC_START && h < H_SYNC_END);
    exp_vsync = !(v >= V_SYNC_START && v < V_SYNC_END);
    got = {vga_red, vga_grn, vga_blu};
    if (vga_hsync !== exp_hsync) begin
      report_mismatch($sformatf("hsync at (%0d,%0d)", h, v), 32'(exp_hsync), 32'(vga_hsync));
    end
    if (vga_vsync !== exp_vsync) begin
      report_mismatch($sformatf("vsync at (%0d,%0d)", h, v), 32'(exp_vsync), 32'(vga_vsync));
    end
    if (vga_error !== 1'b0) begin
      report_mismatch($sformatf("error at (%0d,%0d)", h, v), 32'd0, 32'(vga_error));
    end
    if ((h >= H_VISIBLE || v >= V_VISIBLE) && got !== '0) begin
      report_mismatch($sformatf("blanking at (%0d,%0d)", h, v), 32'd0, 32'(got));
    end
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (tab_frame[i] == frame && tab_x[i] == h && tab_y[i] == v) begin
        tab_hit[i] = 1'b1;
        table_checks++;
        if (got !== tab_exp[i]) begin
          report_mismatch($sformatf("pixel frame %0d (%0d,%0d)", frame, h, v),
                          32'(tab_exp[i]), 32'(got));
        end
      end
    end
  endtask

  initial begin
    int   h;
    int   v;
    int   frame;
    logic fell;
    errors       = 0;
    table_checks = 0;
    cycle_cnt    = 0;
    last_hfall   = -1;
    last_vfall   = -1;
    prev_hsync   = 1'b1;
    prev_vsync   = 1'b1;
    rst_n        = 1'b0;
    lcg_state    = 32'he6ddf542;
    build_table();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // the first frame takes FB_DEPTH cycles to draw, so nothing can be shown yet
    repeat (FB_DEPTH) begin
      @(negedge clk);
      if (vga_hsync !== 1'b1) begin
        report_mismatch("idle hsync", 32'd1, 32'(vga_hsync));
      end
      if (vga_vsync !== 1'b1) begin
        report_mismatch("idle vsync", 32'd1, 32'(vga_vsync));
      end
      if ({vga_red, vga_grn, vga_blu} !== '0) begin
        report_mismatch("idle colors", 32'd0, 32'({vga_red, vga_grn, vga_blu}));
      end
      if (vga_error !== 1'b0) begin
        report_mismatch("idle error", 32'd0, 32'(vga_error));
      end
      track_sync();
    end

    // first falling vsync marks column 0 of line V_SYNC_START
    do begin
      @(negedge clk);
      if (vga_error !== 1'b0) begin
        report_mismatch("error before alignment", 32'd0, 32'(vga_error));
      end
      fell = (prev_vsync === 1'b1) && (vga_vsync === 1'b0);
      track_sync();
    end while (!fell);

    h     = 0;
    v     = V_SYNC_START;
    frame = -1;
    check_position(frame, h, v);
    while (frame < NUM_FRAMES) begin
      h++;
      if (h == LINE_CYCLES) begin
        h = 0;
        v++;
        if (v == FRAME_LINES) begin
          v = 0;
          frame++;
        end
      end
      if (frame < NUM_FRAMES) begin
        @(negedge clk);
        check_position(frame, h, v);
        track_sync();
      end
    end

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (!tab_hit[i]) begin
        $display("table entry %0d at frame %0d (%0d,%0d) was never reached",
                 i, tab_frame[i], tab_x[i], tab_y[i]);
        errors++;
      end
    end
    $display("errors: %0d, table positions checked: %0d", errors, table_checks);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: verilog/gfx_pattern_demo.sv
`timescale 1ns/1ps

module gfx_pattern_demo (
  input  logic                          clk,
  input  logic                          rst_n,
  output logic [fb_pkg::COLOR_WIDTH-1:0] vga_red,
  output logic [fb_pkg::COLOR_WIDTH-1:0] vga_grn,
  output logic [fb_pkg::COLOR_WIDTH-1:0] vga_blu,
  output logic                          vga_hsync,
  output logic                          vga_vsync,
  output logic                          vga_error
);
  import fb_pkg::*;

  logic     pat_start;
  logic     pat_done;
  logic     rd_enable;

  logic     wr_en;
  fb_addr_t wr_addr;
  pixel_t   wr_pixel;

  logic     rd_en;
  fb_addr_t rd_addr;
  logic     rd_valid;
  pixel_t   rd_pixel;

  logic     pix_valid;
  pixel_t   pix_data;
  logic     pix_ready;

  // redraw forever, reader waits for the first complete frame
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pat_start <= 1'b1;
      rd_enable <= 1'b0;
    end else begin
      pat_start <= pat_done;
      rd_enable <= rd_enable || pat_done;
    end
  end

  gfx_pattern gfx_pattern_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (pat_start),
    .done    (pat_done),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_pixel(wr_pixel)
  );

  fb_stripe fb_stripe_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_pixel(wr_pixel),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_valid(rd_valid),
    .rd_pixel(rd_pixel)
  );

  fb_reader fb_reader_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .enable   (rd_enable),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_valid (rd_valid),
    .rd_pixel (rd_pixel),
    .pix_valid(pix_valid),
    .pix_data (pix_data),
    .pix_ready(pix_ready)
  );

  vga_timing vga_timing_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .pix_valid(pix_valid),
    .pix_data (pix_data),
    .pix_ready(pix_ready),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync),
    .vga_error(vga_error)
  );

endmodule

// File: verilog/vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          pix_valid,
  input  fb_pkg::pixel_t                pix_data,
  output logic                          pix_ready,
  output logic [fb_pkg::COLOR_WIDTH-1:0] vga_red,
  output logic [fb_pkg::COLOR_WIDTH-1:0] vga_grn,
  output logic [fb_pkg::COLOR_WIDTH-1:0] vga_blu,
  output logic                          vga_hsync,
  output logic                          vga_vsync,
  output logic                          vga_error
);
  import fb_pkg::*;

  logic running;
  h_t   h;
  v_t   v;
  logic visible;
  logic hsync_active;
  logic vsync_active;

  assign visible      = running && (h < h_t'(H_VISIBLE)) && (v < v_t'(V_VISIBLE));
  assign hsync_active = (h >= h_t'(H_SYNC_START)) && (h < h_t'(H_SYNC_END));
  assign vsync_active = (v >= v_t'(V_SYNC_START)) && (v < v_t'(V_SYNC_END));
  assign pix_ready    = visible;

  // idle until the first pixel shows up, then free running
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      running <= 1'b0;
      h       <= '0;
      v       <= '0;
    end else if (!running) begin
      running <= pix_valid;
      h       <= '0;
      v       <= '0;
    end else if (h == h_t'(H_LINE_END)) begin
      h <= '0;
      if (v == v_t'(V_FRAME_END)) begin
        v <= '0;
      end else begin
        v <= v + 1'b1;
      end
    end else begin
      h <= h + 1'b1;
    end
  end

  // everything for position (h, v) lands on the same edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_error <= 1'b0;
    end else begin
      vga_red   <= visible ? pix_data.red : '0;
      vga_grn   <= visible ? pix_data.grn : '0;
      vga_blu   <= visible ? pix_data.blu : '0;
      vga_hsync <= !(running && hsync_active);
      vga_vsync <= !(running && vsync_active);
      // sticky underflow
      vga_error <= vga_error || (visible && !pix_valid);
    end
  end

  a_no_blank_accept: assert property (@(posedge clk) disable iff (!rst_n)
    (pix_valid && pix_ready) |-> (h < h_t'(H_VISIBLE)) && (v < v_t'(V_VISIBLE)));

endmodule

// File: verilog/fb_reader.sv
`timescale 1ns/1ps

module fb_reader (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             enable,
  output logic             rd_en,
  output fb_pkg::fb_addr_t rd_addr,
  input  logic             rd_valid,
  input  fb_pkg::pixel_t   rd_pixel,
  output logic             pix_valid,
  output fb_pkg::pixel_t   pix_data,
  input  logic             pix_ready
);
  import fb_pkg::*;

  pixel_t    fifo_mem[PIX_FIFO_DEPTH];
  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  fifo_cnt_t count;
  // free slots, with reads still in flight counted as taken
  fifo_cnt_t credits;
  logic      pop;

  assign rd_en     = enable && (credits != '0);
  assign pop       = pix_valid && pix_ready;
  assign pix_valid = (count != '0);
  assign pix_data  = fifo_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_addr <= '0;
    end else if (rd_en) begin
      if (rd_addr == fb_addr_t'(FB_DEPTH - 1)) begin
        rd_addr <= '0;
      end else begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= fifo_cnt_t'(PIX_FIFO_DEPTH);
    end else begin
      case ({rd_en, pop})
        2'b10:   credits <= credits - fifo_cnt_t'(1);
        2'b01:   credits <= credits + fifo_cnt_t'(1);
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (rd_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({rd_valid, pop})
        2'b10:   count <= count + fifo_cnt_t'(1);
        2'b01:   count <= count - fifo_cnt_t'(1);
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid) begin
      fifo_mem[wr_ptr] <= rd_pixel;
    end
  end

  // returning data must always find a slot, which the credit count guarantees
  a_fifo_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid |-> (count < fifo_cnt_t'(PIX_FIFO_DEPTH)) || pop);

endmodule

// File: verilog/fb_stripe.sv
`timescale 1ns/1ps

module fb_stripe (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wr_en,
  input  fb_pkg::fb_addr_t wr_addr,
  input  fb_pkg::pixel_t   wr_pixel,
  input  logic             rd_en,
  input  fb_pkg::fb_addr_t rd_addr,
  output logic             rd_valid,
  output fb_pkg::pixel_t   rd_pixel
);
  import fb_pkg::*;

  pixel_t    bank_rd[NUM_S];
  logic      rd_valid_p1;
  bank_sel_t sel_p1;

  // low bits pick the bank, upper bits index inside it
  for (genvar i = 0; i < NUM_S; i++) begin : gen_bank
    fb_bank fb_bank_i (
      .clk    (clk),
      .wr_en  (wr_en && (wr_addr[BANK_SEL_WIDTH-1:0] == bank_sel_t'(i))),
      .wr_addr(wr_addr[FB_ADDR_WIDTH-1:BANK_SEL_WIDTH]),
      .wr_data(wr_pixel),
      .rd_addr(rd_addr[FB_ADDR_WIDTH-1:BANK_SEL_WIDTH]),
      .rd_data(bank_rd[i])
    );
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid_p1 <= 1'b0;
      rd_valid    <= 1'b0;
    end else begin
      rd_valid_p1 <= rd_en;
      rd_valid    <= rd_valid_p1;
    end
  end

  // second stage steers the bank word chosen at request time
  always_ff @(posedge clk) begin
    sel_p1   <= rd_addr[BANK_SEL_WIDTH-1:0];
    rd_pixel <= bank_rd[sel_p1];
  end

  a_rd_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
    rd_en |-> (int'(rd_addr) < FB_DEPTH));

endmodule

// File: verilog/fb_bank.sv
`timescale 1ns/1ps

module fb_bank (
  input  logic               clk,
  input  logic               wr_en,
  input  fb_pkg::bank_addr_t wr_addr,
  input  fb_pkg::pixel_t     wr_data,
  input  fb_pkg::bank_addr_t rd_addr,
  output fb_pkg::pixel_t     rd_data
);
  import fb_pkg::*;

  pixel_t mem[BANK_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: verilog/gfx_pattern.sv
`timescale 1ns/1ps

module gfx_pattern (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  output logic             done,
  output logic             wr_en,
  output fb_pkg::fb_addr_t wr_addr,
  output fb_pkg::pixel_t   wr_pixel
);
  import fb_pkg::*;

  h_t x;
  v_t y;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_en   <= 1'b0;
      done    <= 1'b0;
      x       <= '0;
      y       <= '0;
      wr_addr <= '0;
    end else begin
      done <= 1'b0;
      if (wr_en) begin
        wr_addr <= wr_addr + 1'b1;
        if (x == h_t'(H_VISIBLE - 1)) begin
          x <= '0;
          if (y == v_t'(V_VISIBLE - 1)) begin
            // last write of the frame is in this cycle
            y     <= '0;
            wr_en <= 1'b0;
            done  <= 1'b1;
          end else begin
            y <= y + 1'b1;
          end
        end else begin
          x <= x + 1'b1;
        end
      end else if (start) begin
        wr_en   <= 1'b1;
        x       <= '0;
        y       <= '0;
        wr_addr <= '0;
      end
    end
  end

  // red follows x, green follows y, blue is the xor pattern
  always_comb begin
    wr_pixel.red = COLOR_WIDTH'(x);
    wr_pixel.grn = COLOR_WIDTH'(y);
    wr_pixel.blu = COLOR_WIDTH'(x ^ h_t'(y));
  end

endmodule

// File: verilog/fb_pkg.sv
package fb_pkg;

  localparam int COLOR_WIDTH = 4;

  typedef struct packed {
    logic [COLOR_WIDTH-1:0] red;
    logic [COLOR_WIDTH-1:0] grn;
    logic [COLOR_WIDTH-1:0] blu;
  } pixel_t;

  // small test mode, columns and lines count from 0
  localparam int H_VISIBLE    = 8;
  localparam int H_SYNC_START = 10;
  localparam int H_SYNC_END   = 12;
  localparam int H_LINE_END   = 13;

  localparam int V_VISIBLE    = 4;
  localparam int V_SYNC_START = 5;
  localparam int V_SYNC_END   = 6;
  localparam int V_FRAME_END  = 6;

  localparam int H_WIDTH = 4;
  localparam int V_WIDTH = 3;

  typedef logic [H_WIDTH-1:0] h_t;
  typedef logic [V_WIDTH-1:0] v_t;

  localparam int FB_DEPTH      = H_VISIBLE * V_VISIBLE;
  localparam int FB_ADDR_WIDTH = 5;

  // linear address is y * H_VISIBLE + x
  typedef logic [FB_ADDR_WIDTH-1:0] fb_addr_t;

  localparam int NUM_S           = 2;
  localparam int BANK_SEL_WIDTH  = $clog2(NUM_S);
  localparam int BANK_DEPTH      = FB_DEPTH / NUM_S;
  localparam int BANK_ADDR_WIDTH = FB_ADDR_WIDTH - BANK_SEL_WIDTH;

  typedef logic [BANK_SEL_WIDTH-1:0]  bank_sel_t;
  typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;

  localparam int READ_LATENCY = 2;

  // reader prefetch FIFO
  localparam int PIX_FIFO_DEPTH     = 4;
  localparam int PIX_FIFO_PTR_WIDTH = $clog2(PIX_FIFO_DEPTH);

  typedef logic [PIX_FIFO_PTR_WIDTH-1:0] fifo_ptr_t;
  typedef logic [PIX_FIFO_PTR_WIDTH:0]   fifo_cnt_t;

endpackage
